// File: eth_mac_core.f
eth_mac_pkg.sv
frame_ring.sv
mac_control.sv
tx_framer.sv
rx_deframer.sv
eth_mac_core.sv
tb_eth_mac_core.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_eth_mac_core \
    -f eth_mac_core.f -o tb_eth_mac_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_eth_mac_core > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

// File: tb_eth_mac_core.sv
`timescale 1ns/1ps

module tb_eth_mac_core;

    typedef logic [eth_mac_pkg::len_bits-1:0] len_t;

    localparam int num_tests = 6;
    localparam int src_loop = 0;
    localparam int src_inject = 1;
    localparam int bad_none = 0;
    localparam int bad_fcs = 1;
    localparam int bad_rx_er = 2;

    string test_name [num_tests] = '{"loop_one", "loop_mid", "loop_long",
        "inject_good", "inject_bad_fcs", "inject_rx_er"};
    int test_len [num_tests] = '{1, 23, 60, 17, 20, 30};
    int test_src [num_tests] = '{src_loop, src_loop, src_loop,
        src_inject, src_inject, src_inject};
    int test_bad [num_tests] = '{bad_none, bad_none, bad_none, bad_none, bad_fcs, bad_rx_er};

    logic clock;
    logic reset;
    logic cmd_req;
    logic [1:0] cmd_op;
    logic [7:0] cmd_data;
    logic cmd_ack;
    logic [7:0] rsp_data;
    len_t rsp_len;
    logic rsp_error;
    logic [7:0] gmii_txd;
    logic gmii_tx_en;
    logic [7:0] gmii_rxd;
    logic gmii_rx_dv;
    logic gmii_rx_er;

    logic loop_mode;
    logic [7:0] inj_data;
    logic inj_dv;
    logic inj_er;
    logic [7:0] payload [eth_mac_pkg::max_frame];
    logic [7:0] got_data;
    len_t got_len;
    logic got_error;
    logic [7:0] tx_bytes [$];
    int runs [$];    // tx_en high cycles per frame
    int gaps [$];    // tx_en low cycles before each frame
    int high_run;
    int low_run;
    logic tx_was_on;

    eth_mac_core dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // rx pins follow the tx pins or the injected bytes
    initial begin
        gmii_rxd = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        forever begin
            @(posedge clock);
            gmii_rxd <= loop_mode ? gmii_txd : inj_data;
            gmii_rx_dv <= loop_mode ? gmii_tx_en : inj_dv;
            gmii_rx_er <= loop_mode ? 1'b0 : inj_er;
        end
    end

    initial begin
        high_run = 0;
        low_run = 0;
        tx_was_on = 1'b0;
        forever begin
            @(posedge clock);
            if (gmii_tx_en === 1'b1) begin
                tx_bytes.push_back(gmii_txd);
                if (!tx_was_on) begin
                    gaps.push_back(low_run);
                    high_run = 0;
                end
                high_run++;
            end else begin
                if (tx_was_on) begin
                    runs.push_back(high_run);
                    low_run = 0;
                end
                low_run++;
            end
            tx_was_on = (gmii_tx_en === 1'b1);
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
            input logic [7:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_len(input string name, input len_t expected, input len_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // reflected crc-32, one bit at a time
    function automatic logic [31:0] ref_fcs(input int len);
        logic [31:0] c;
        logic fb;
        c = 32'hffff_ffff;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ payload[i][b];
                c = fb ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic host_cmd(input logic [1:0] op, input logic [7:0] data);
        int t;
        @(posedge clock);
        cmd_op <= op;
        cmd_data <= data;
        cmd_req <= 1'b1;
        t = 0;
        while (cmd_ack !== 1'b1) begin
            @(posedge clock);
            t++;
            if (t > 20) stop_with_failure("cmd_ack never rose after a request");
        end
        got_data = rsp_data;
        got_len = rsp_len;
        got_error = rsp_error;
        cmd_req <= 1'b0;
        t = 0;
        while (cmd_ack !== 1'b0) begin
            @(posedge clock);
            t++;
            if (t > 20) stop_with_failure("cmd_ack never fell after the request dropped");
        end
    endtask

    task automatic write_frame(input string name, input int len, input logic send);
        for (int i = 0; i < len; i++) begin
            payload[i] = 8'($urandom());
            host_cmd(eth_mac_pkg::op_write_byte, payload[i]);
            check_flag({name, " write"}, 1'b0, got_error);
        end
        if (send) begin
            host_cmd(eth_mac_pkg::op_send_frame, 8'h00);
            check_flag({name, " send"}, 1'b0, got_error);
        end
    endtask

    task automatic wait_runs(input int target);
        int t;
        t = 0;
        while (runs.size() < target) begin
            @(posedge clock);
            t++;
            if (t > 1000) stop_with_failure("transmit frame did not finish in time");
        end
    endtask

    task automatic check_tx(input string name, input int len, input int idx);
        logic [31:0] fcs;
        logic [7:0] expected;
        fcs = ref_fcs(len);
        check_len({name, " tx_en cycles"}, len_t'(len + 12), len_t'(runs[idx]));
        for (int i = 0; i < len + 12; i++) begin
            if (i < 7) expected = 8'h55;
            else if (i == 7) expected = 8'hd5;
            else if (i < len + 8) expected = payload[i - 8];
            else expected = fcs[8 * (i - len - 8) +: 8];    // fcs lsb first
            check_byte({name, " tx byte"}, expected, tx_bytes[i]);
        end
    endtask

    task automatic inject_frame(input int len, input int kind);
        logic [7:0] frame [$];
        logic [31:0] fcs;
        fcs = ref_fcs(len) ^ ((kind == bad_fcs) ? 32'h0000_0001 : 32'h0);
        for (int i = 0; i < 7; i++) frame.push_back(8'h55);
        frame.push_back(8'hd5);
        for (int i = 0; i < len; i++) frame.push_back(payload[i]);
        for (int k = 0; k < 4; k++) frame.push_back(fcs[8 * k +: 8]);
        foreach (frame[i]) begin
            @(posedge clock);
            inj_data <= frame[i];
            inj_dv <= 1'b1;
            inj_er <= (kind == bad_rx_er) && (i == 8 + len / 2);    // mid payload
        end
        @(posedge clock);
        inj_dv <= 1'b0;
        inj_er <= 1'b0;
        repeat (2) @(posedge clock);    // forwarding stage, then readable a cycle after dv falls
    endtask

    task automatic expect_no_frame(input string name);
        host_cmd(eth_mac_pkg::op_read_byte, 8'h00);
        check_flag({name, " read with no frame"}, 1'b1, got_error);
    endtask

    task automatic read_back(input string name, input int len);
        for (int i = 0; i < len; i++) begin
            host_cmd(eth_mac_pkg::op_read_byte, 8'h00);
            check_flag({name, " read"}, 1'b0, got_error);
            check_byte({name, " rx byte"}, payload[i], got_data);
            check_len({name, " rx length"}, len_t'(len), got_len);
        end
        host_cmd(eth_mac_pkg::op_read_byte, 8'h00);
        check_flag({name, " read past end"}, 1'b1, got_error);
        host_cmd(eth_mac_pkg::op_drop_frame, 8'h00);
        check_flag({name, " drop"}, 1'b0, got_error);
        expect_no_frame(name);
    endtask

    initial begin
        int r0;
        int g0;
        reset = 1'b1;
        cmd_req = 1'b0;
        cmd_op = 2'd0;
        cmd_data = 8'h00;
        loop_mode = 1'b0;
        inj_data = 8'h00;
        inj_dv = 1'b0;
        inj_er = 1'b0;
        void'($urandom(32));
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_flag("after reset cmd_ack", 1'b0, cmd_ack);
        check_flag("after reset gmii_tx_en", 1'b0, gmii_tx_en);
        check_flag("after reset rsp_error", 1'b0, rsp_error);
        expect_no_frame("after reset");

        for (int n = 0; n < num_tests; n++) begin
            if (test_src[n] == src_loop) begin
                loop_mode <= 1'b1;
                tx_bytes.delete();
                r0 = runs.size();
                write_frame(test_name[n], test_len[n], 1'b1);
                wait_runs(r0 + 1);
                check_tx(test_name[n], test_len[n], r0);
                read_back(test_name[n], test_len[n]);
            end else begin
                loop_mode <= 1'b0;
                for (int i = 0; i < test_len[n]; i++) payload[i] = 8'($urandom());
                inject_frame(test_len[n], test_bad[n]);
                if (test_bad[n] == bad_none) read_back(test_name[n], test_len[n]);
                else expect_no_frame(test_name[n]);
            end
        end
        loop_mode <= 1'b0;

        // long frame keeps the framer busy while the short one is committed
        r0 = runs.size();
        g0 = gaps.size();
        write_frame("back_to_back", 60, 1'b1);
        write_frame("back_to_back", 4, 1'b1);
        wait_runs(r0 + 2);
        check_len("back_to_back first", len_t'(72), len_t'(runs[r0]));
        check_len("back_to_back second", len_t'(16), len_t'(runs[r0 + 1]));
        check_flag("back_to_back gap", 1'b1, gaps[g0 + 1] >= 12);

        tx_bytes.delete();
        r0 = runs.size();
        write_frame("overflow", 64, 1'b0);
        host_cmd(eth_mac_pkg::op_write_byte, 8'hff);
        check_flag("overflow 65th write", 1'b1, got_error);
        host_cmd(eth_mac_pkg::op_send_frame, 8'h00);
        check_flag("overflow send", 1'b0, got_error);
        wait_runs(r0 + 1);
        check_tx("overflow", 64, r0);
        host_cmd(eth_mac_pkg::op_send_frame, 8'h00);
        check_flag("empty send", 1'b1, got_error);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: eth_mac_core.sv
`timescale 1ns/1ps

module eth_mac_core (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             cmd_req,
    input  logic [1:0]                       cmd_op,
    input  logic [7:0]                       cmd_data,
    output logic                             cmd_ack,
    output logic [7:0]                       rsp_data,
    output logic [eth_mac_pkg::len_bits-1:0] rsp_len,
    output logic                             rsp_error,
    output logic [7:0]                       gmii_txd,
    output logic                             gmii_tx_en,
    input  logic [7:0]                       gmii_rxd,
    input  logic                             gmii_rx_dv,
    input  logic                             gmii_rx_er
);

    logic tx_wr_en;
    logic [7:0] tx_wr_data;
    logic tx_wr_commit;
    logic tx_wr_full;
    logic [eth_mac_pkg::len_bits-1:0] tx_wr_count;
    logic [eth_mac_pkg::len_bits-1:0] tx_rd_index;
    logic tx_rd_release;
    logic [7:0] tx_rd_data;
    logic [eth_mac_pkg::len_bits-1:0] tx_rd_len;
    logic tx_rd_avail;

    logic rx_wr_en;
    logic [7:0] rx_wr_data;
    logic rx_wr_commit;
    logic rx_wr_abort;
    logic rx_wr_full;
    logic [eth_mac_pkg::len_bits-1:0] rx_wr_count;
    logic [eth_mac_pkg::len_bits-1:0] rx_rd_index;
    logic rx_rd_release;
    logic [7:0] rx_rd_data;
    logic [eth_mac_pkg::len_bits-1:0] rx_rd_len;
    logic rx_rd_avail;

    mac_control control0 (
        .clock      (clock),
        .reset      (reset),
        .cmd_req    (cmd_req),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack),
        .rsp_data   (rsp_data),
        .rsp_len    (rsp_len),
        .rsp_error  (rsp_error),
        .wr_en      (tx_wr_en),
        .wr_data    (tx_wr_data),
        .wr_commit  (tx_wr_commit),
        .wr_full    (tx_wr_full),
        .wr_count   (tx_wr_count),
        .rd_index   (rx_rd_index),
        .rd_release (rx_rd_release),
        .rd_data    (rx_rd_data),
        .rd_len     (rx_rd_len),
        .rd_avail   (rx_rd_avail)
    );

    frame_ring tx_ring0 (
        .clock      (clock),
        .reset      (reset),
        .wr_en      (tx_wr_en),
        .wr_data    (tx_wr_data),
        .wr_commit  (tx_wr_commit),
        .wr_abort   (1'b0),    // host frames are never discarded
        .wr_full    (tx_wr_full),
        .wr_count   (tx_wr_count),
        .rd_index   (tx_rd_index),
        .rd_release (tx_rd_release),
        .rd_data    (tx_rd_data),
        .rd_len     (tx_rd_len),
        .rd_avail   (tx_rd_avail)
    );

    frame_ring rx_ring0 (
        .clock      (clock),
        .reset      (reset),
        .wr_en      (rx_wr_en),
        .wr_data    (rx_wr_data),
        .wr_commit  (rx_wr_commit),
        .wr_abort   (rx_wr_abort),
        .wr_full    (rx_wr_full),
        .wr_count   (rx_wr_count),
        .rd_index   (rx_rd_index),
        .rd_release (rx_rd_release),
        .rd_data    (rx_rd_data),
        .rd_len     (rx_rd_len),
        .rd_avail   (rx_rd_avail)
    );

    tx_framer tx_framer0 (
        .clock      (clock),
        .reset      (reset),
        .rd_avail   (tx_rd_avail),
        .rd_len     (tx_rd_len),
        .rd_data    (tx_rd_data),
        .rd_index   (tx_rd_index),
        .rd_release (tx_rd_release),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    rx_deframer rx_deframer0 (
        .clock      (clock),
        .reset      (reset),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .wr_full    (rx_wr_full),
        .wr_count   (rx_wr_count),
        .wr_en      (rx_wr_en),
        .wr_data    (rx_wr_data),
        .wr_commit  (rx_wr_commit),
        .wr_abort   (rx_wr_abort)
    );

endmodule

// File: rx_deframer.sv
`timescale 1ns/1ps

module rx_deframer (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [7:0]                       gmii_rxd,
    input  logic                             gmii_rx_dv,
    input  logic                             gmii_rx_er,
    input  logic                             wr_full,
    input  logic [eth_mac_pkg::len_bits-1:0] wr_count,
    output logic                             wr_en,
    output logic [7:0]                       wr_data,
    output logic                             wr_commit,
    output logic                             wr_abort
);

    logic [2:0] state;
    logic [2:0] pre_cnt;    // preamble bytes seen
    logic [31:0] crc;
    logic in_data;
    logic good;

    assign in_data = (state == eth_mac_pkg::st_data);
    // residue covers payload and fcs, minimum one payload byte
    assign good = (crc == eth_mac_pkg::crc_residue) && (wr_count >= 7'd5);

    assign wr_data = gmii_rxd;
    assign wr_en = in_data && gmii_rx_dv && !gmii_rx_er
        && (wr_count < eth_mac_pkg::max_frame);
    assign wr_commit = in_data && !gmii_rx_dv && good;
    assign wr_abort = in_data && (gmii_rx_dv ? !wr_en : !good);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= eth_mac_pkg::st_idle;
            pre_cnt <= '0;
            crc <= eth_mac_pkg::crc_init;
        end else if (!gmii_rx_dv) begin
            state <= eth_mac_pkg::st_idle;    // frame end, commit or abort fired above
        end else begin
            case (state)
                eth_mac_pkg::st_idle: begin
                    pre_cnt <= 3'd1;
                    if ((gmii_rxd == eth_mac_pkg::preamble_byte) && !gmii_rx_er) begin
                        state <= eth_mac_pkg::st_pre;
                    end else begin
                        state <= eth_mac_pkg::st_drop;
                    end
                end
                eth_mac_pkg::st_pre: begin
                    if (gmii_rx_er) begin
                        state <= eth_mac_pkg::st_drop;
                    end else if ((gmii_rxd == eth_mac_pkg::preamble_byte)
                            && (pre_cnt < eth_mac_pkg::preamble_len)) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end else if ((gmii_rxd == eth_mac_pkg::sfd_byte)
                            && (pre_cnt == eth_mac_pkg::preamble_len) && !wr_full) begin
                        crc <= eth_mac_pkg::crc_init;
                        state <= eth_mac_pkg::st_data;
                    end else begin
                        state <= eth_mac_pkg::st_drop;    // bad preamble or no free slot
                    end
                end
                eth_mac_pkg::st_data: begin
                    if (wr_en) begin
                        crc <= eth_mac_pkg::next_crc(crc, gmii_rxd);
                    end else begin
                        state <= eth_mac_pkg::st_drop;    // rx_er or too long
                    end
                end
                default: state <= eth_mac_pkg::st_drop;
            endcase
        end
    end

endmodule

// File: tx_framer.sv
`timescale 1ns/1ps

module tx_framer (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             rd_avail,
    input  logic [eth_mac_pkg::len_bits-1:0] rd_len,
    input  logic [7:0]                       rd_data,
    output logic [eth_mac_pkg::len_bits-1:0] rd_index,
    output logic                             rd_release,
    output logic [7:0]                       gmii_txd,
    output logic                             gmii_tx_en
);

    logic [2:0] state;
    logic [3:0] cnt;    // position in preamble, fcs or gap
    logic [31:0] crc;

    assign rd_release = (state == eth_mac_pkg::st_fcs) && (cnt == 4'd4);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= eth_mac_pkg::st_idle;
            cnt <= '0;
            crc <= eth_mac_pkg::crc_init;
            rd_index <= '0;
            gmii_txd <= 8'h00;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                eth_mac_pkg::st_idle: begin
                    if (rd_avail) begin
                        gmii_tx_en <= 1'b1;
                        gmii_txd <= eth_mac_pkg::preamble_byte;
                        cnt <= 4'd1;
                        crc <= eth_mac_pkg::crc_init;
                        rd_index <= '0;
                        state <= eth_mac_pkg::st_pre;
                    end
                end
                eth_mac_pkg::st_pre: begin
                    if (cnt < eth_mac_pkg::preamble_len) begin
                        gmii_txd <= eth_mac_pkg::preamble_byte;
                        cnt <= cnt + 1'b1;
                    end else begin
                        gmii_txd <= eth_mac_pkg::sfd_byte;
                        state <= eth_mac_pkg::st_sfd;
                    end
                end
                eth_mac_pkg::st_sfd, eth_mac_pkg::st_data: begin
                    if (rd_index < rd_len) begin
                        gmii_txd <= rd_data;
                        crc <= eth_mac_pkg::next_crc(crc, rd_data);
                        rd_index <= rd_index + 1'b1;
                        state <= eth_mac_pkg::st_data;
                    end else begin
                        gmii_txd <= ~crc[7:0];    // fcs goes out lsb first
                        cnt <= 4'd1;
                        state <= eth_mac_pkg::st_fcs;
                    end
                end
                eth_mac_pkg::st_fcs: begin
                    if (cnt < 4'd4) begin
                        gmii_txd <= ~crc[{cnt[1:0], 3'b000} +: 8];
                        cnt <= cnt + 1'b1;
                    end else begin
                        gmii_tx_en <= 1'b0;
                        gmii_txd <= 8'h00;
                        cnt <= 4'd1;
                        state <= eth_mac_pkg::st_gap;
                    end
                end
                eth_mac_pkg::st_gap: begin
                    if (cnt < eth_mac_pkg::ifg_cycles) begin
                        cnt <= cnt + 1'b1;
                    end else begin
                        state <= eth_mac_pkg::st_idle;
                    end
                end
                default: state <= eth_mac_pkg::st_idle;
            endcase
        end
    end

    a_gap_low: assert property (@(posedge clock) disable iff (reset)
        $fell(gmii_tx_en) |-> !gmii_tx_en [*eth_mac_pkg::ifg_cycles]);

endmodule

// File: mac_control.sv
`timescale 1ns/1ps

module mac_control (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             cmd_req,
    input  logic [1:0]                       cmd_op,
    input  logic [7:0]                       cmd_data,
    output logic                             cmd_ack,
    output logic [7:0]                       rsp_data,
    output logic [eth_mac_pkg::len_bits-1:0] rsp_len,
    output logic                             rsp_error,
    output logic                             wr_en,
    output logic [7:0]                       wr_data,
    output logic                             wr_commit,
    input  logic                             wr_full,
    input  logic [eth_mac_pkg::len_bits-1:0] wr_count,
    output logic [eth_mac_pkg::len_bits-1:0] rd_index,
    output logic                             rd_release,
    input  logic [7:0]                       rd_data,
    input  logic [eth_mac_pkg::len_bits-1:0] rd_len,
    input  logic                             rd_avail
);

    logic fire;    // first cycle of a request
    logic [eth_mac_pkg::len_bits-1:0] rd_ptr;
    logic [eth_mac_pkg::len_bits-1:0] rx_len;
    logic write_ok;
    logic send_ok;
    logic read_ok;

    assign fire = cmd_req && !cmd_ack;
    assign rx_len = rd_len - 7'd4;    // received slots still hold the fcs
    assign write_ok = !wr_full && (wr_count < eth_mac_pkg::max_frame);
    assign send_ok = !wr_full && (wr_count != 0);
    assign read_ok = rd_avail && (rd_ptr < rx_len);

    assign wr_en = fire && (cmd_op == eth_mac_pkg::op_write_byte) && write_ok;
    assign wr_data = cmd_data;
    assign wr_commit = fire && (cmd_op == eth_mac_pkg::op_send_frame) && send_ok;
    assign rd_release = fire && (cmd_op == eth_mac_pkg::op_drop_frame) && rd_avail;
    assign rd_index = rd_ptr;

    always_ff @(posedge clock) begin
        if (reset) begin
            cmd_ack <= 1'b0;
            rsp_error <= 1'b0;
            rd_ptr <= '0;
        end else if (fire) begin
            cmd_ack <= 1'b1;
            case (cmd_op)
                eth_mac_pkg::op_write_byte: begin
                    rsp_error <= !write_ok;
                end
                eth_mac_pkg::op_send_frame: begin
                    rsp_error <= !send_ok;    // open frame stays on error
                end
                eth_mac_pkg::op_read_byte: begin
                    rsp_error <= !read_ok;
                    if (read_ok) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                end
                eth_mac_pkg::op_drop_frame: begin
                    rsp_error <= !rd_avail;
                    rd_ptr <= '0;
                end
            endcase
        end else if (!cmd_req && cmd_ack) begin
            cmd_ack <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fire && (cmd_op == eth_mac_pkg::op_read_byte)) begin
            rsp_data <= rd_data;
            rsp_len <= rx_len;
        end
    end

    // host keeps req up until ack answers it
    a_ack_after_req: assert property (@(posedge clock) disable iff (reset)
        $rose(cmd_ack) |-> cmd_req);

endmodule

// File: frame_ring.sv
`timescale 1ns/1ps

module frame_ring (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             wr_en,
    input  logic [7:0]                       wr_data,
    input  logic                             wr_commit,
    input  logic                             wr_abort,
    output logic                             wr_full,
    output logic [eth_mac_pkg::len_bits-1:0] wr_count,
    input  logic [eth_mac_pkg::len_bits-1:0] rd_index,
    input  logic                             rd_release,
    output logic [7:0]                       rd_data,
    output logic [eth_mac_pkg::len_bits-1:0] rd_len,
    output logic                             rd_avail
);

    logic [7:0] mem [eth_mac_pkg::slot_count][eth_mac_pkg::max_frame];
    logic [eth_mac_pkg::len_bits-1:0] len_mem [eth_mac_pkg::slot_count];
    logic [eth_mac_pkg::slot_bits-1:0] head;    // oldest closed slot
    logic [eth_mac_pkg::slot_bits-1:0] tail;    // slot being filled
    logic [eth_mac_pkg::slot_bits:0] fill;

    assign wr_full = (fill == eth_mac_pkg::slot_count);
    assign rd_avail = (fill != 0);
    assign rd_len = len_mem[head];
    assign rd_data = mem[head][rd_index[eth_mac_pkg::len_bits-2:0]];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[tail][wr_count[eth_mac_pkg::len_bits-2:0]] <= wr_data;
        end
        if (wr_commit) begin
            len_mem[tail] <= wr_count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            fill <= '0;
            wr_count <= '0;
        end else begin
            if (wr_commit || wr_abort) begin
                wr_count <= '0;
            end else if (wr_en) begin
                wr_count <= wr_count + 1'b1;
            end
            if (wr_commit) begin
                tail <= tail + 1'b1;
            end
            if (rd_release) begin
                head <= head + 1'b1;
            end
            if (wr_commit && !rd_release) begin
                fill <= fill + 1'b1;
            end else if (rd_release && !wr_commit) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // the writer must hold off while no slot is free
    a_no_write_full: assert property (@(posedge clock) disable iff (reset)
        (wr_en || wr_commit) |-> !wr_full);

    a_no_release_empty: assert property (@(posedge clock) disable iff (reset)
        rd_release |-> rd_avail);

endmodule

// File: eth_mac_pkg.sv
package eth_mac_pkg;

    localparam int slot_count = 4;
    localparam int slot_bits = 2;
    localparam int max_frame = 64;
    localparam int len_bits = 7;

    localparam logic [7:0] preamble_byte = 8'h55;
    localparam int preamble_len = 7;
    localparam logic [7:0] sfd_byte = 8'hd5;
    localparam int ifg_cycles = 12;

    localparam logic [31:0] crc_init = 32'hffff_ffff;
    localparam logic [31:0] crc_residue = 32'hdebb_20e3;    // register after payload and fcs

    localparam logic [1:0] op_write_byte = 2'd0;
    localparam logic [1:0] op_send_frame = 2'd1;
    localparam logic [1:0] op_read_byte = 2'd2;
    localparam logic [1:0] op_drop_frame = 2'd3;

    // framer states, shared by tx and rx
    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_pre = 3'd1;
    localparam logic [2:0] st_sfd = 3'd2;
    localparam logic [2:0] st_data = 3'd3;
    localparam logic [2:0] st_fcs = 3'd4;
    localparam logic [2:0] st_gap = 3'd5;
    localparam logic [2:0] st_drop = 3'd6;

    function automatic logic [31:0] next_crc(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);    // lsb first
        end
        return c;
    endfunction

endpackage
